// File: project.f
design/fetch_pkg.sv
design/if_stage.sv
design/icache.sv
design/fetch_top.sv
verif/fetch_mem_model.sv
verif/tb_fetch_top.sv

// File: Bender.yml
package:
  name: fetch_front_end

sources:
  - files:
      - design/fetch_pkg.sv
      - design/if_stage.sv
      - design/icache.sv
      - design/fetch_top.sv
  - target: test
    files:
      - verif/fetch_mem_model.sv
      - verif/tb_fetch_top.sv

// File: verif/tb_fetch_top.sv
// Fixed seed stall and redirect traffic with redirect targets kept below 0x400
`timescale 1ns/1ps

module tb_fetch_top;
    import fetch_pkg::*;

    localparam int unsigned RESET_CYCLES   = 10;
    localparam int unsigned RUN_CYCLES     = 3000;
    // Run length plus a third for reset and slack
    localparam int unsigned TIMEOUT_CYCLES = RUN_CYCLES + RUN_CYCLES / 3;
    localparam logic [31:0] SEED           = 32'd8;
    // Key of the instruction pattern held in memory
    localparam inst_t       INST_KEY       = 32'h5A3C_96E1;

    logic         clk_i = 1'b0;
    logic         rstn_i;
    logic         stall;
    logic         redirect;
    addr_t        pc_commit;
    mem_req_t     mem_req;
    mem_resp_t    mem_resp;
    if_id_stage_t fetch;

    // Scoreboard state
    logic [31:0]  seed;
    addr_t        exp_pc;
    logic         fault_seen;
    logic         stall_prev;
    logic         redirect_prev;
    logic         req_prev;
    if_id_stage_t fetch_prev;
    int unsigned  gap        = 40;
    int unsigned  cycle_cnt  = 0;
    int unsigned  value_errs = 0;
    int unsigned  flow_errs  = 0;
    int unsigned  pkt_cnt    = 0;
    int unsigned  ex_cnt     = 0;

    fetch_top dut0 (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .stall_i     (stall),
        .redirect_i  (redirect),
        .pc_commit_i (pc_commit),
        .mem_resp_i  (mem_resp),
        .mem_req_o   (mem_req),
        .fetch_o     (fetch)
    );

    fetch_mem_model #(.KEY(INST_KEY), .SEED(SEED)) mem_model0 (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .mem_req_i  (mem_req),
        .mem_resp_o (mem_resp)
    );

    always #5 clk_i = ~clk_i;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Word expected at a byte address
    function automatic inst_t expected_inst(input addr_t a);
        return a[31:0] ^ INST_KEY;
    endfunction

    task automatic report_value(input string name, input logic [191:0] got,
                                input logic [191:0] want);
        value_errs++;
        $display("Fail %s got 0x%0h expected 0x%0h", name, got, want);
    endtask

    task automatic report_flow(input string msg);
        flow_errs++;
        $display("%s", msg);
    endtask

    task automatic check_packet();
        pkt_cnt++;
        assert (!fault_seen) else report_flow("Packet delivered after a misaligned fetch");
        assert (fetch.pc_inst == exp_pc)
            else report_value("fetch_o.pc_inst", fetch.pc_inst, exp_pc);
        assert (fetch.bpred == '0) else report_value("fetch_o.bpred", fetch.bpred, '0);
        if (exp_pc[1:0] != 2'b00) begin
            // Single exception packet for a misaligned target
            assert (fetch.ex.valid) else report_value("fetch_o.ex.valid", fetch.ex.valid, 1'b1);
            assert (fetch.ex.cause == MISALIGNED_FETCH)
                else report_value("fetch_o.ex.cause", fetch.ex.cause, MISALIGNED_FETCH);
            assert (fetch.ex.origin == exp_pc)
                else report_value("fetch_o.ex.origin", fetch.ex.origin, exp_pc);
            fault_seen = 1'b1;
            ex_cnt++;
        end else begin
            assert (!fetch.ex.valid) else report_value("fetch_o.ex.valid", fetch.ex.valid, 1'b0);
            assert (fetch.inst == expected_inst(exp_pc))
                else report_value("fetch_o.inst", fetch.inst, expected_inst(exp_pc));
            exp_pc = exp_pc + 40'd4;
        end
    endtask

    task automatic check_outputs();
        addr_t exp_line;
        exp_line = exp_pc & ~addr_t'(LINE_BITS / 8 - 1);
        if (redirect_prev) begin
            assert (!fetch.valid) else report_flow("Packet valid in the flush cycle of a redirect");
        end else if (stall_prev) begin
            // Whole packet frozen
            assert (fetch === fetch_prev) else report_value("fetch_o", fetch, fetch_prev);
        end else if (fetch.valid) begin
            check_packet();
        end
        // Rising refill request outside the flush cycle of a redirect
        if (mem_req.valid && !req_prev && !redirect_prev) begin
            assert (mem_req.line_addr == exp_line)
                else report_value("mem_req_o.line_addr", mem_req.line_addr, exp_line);
        end
        fetch_prev = fetch;
        req_prev   = mem_req.valid;
    endtask

    task automatic drive_inputs();
        seed  = lcg_next(seed);
        // About one cycle in five stalled
        stall = (seed[31:24] < 8'd51);
        if (gap == 0) begin
            seed      = lcg_next(seed);
            redirect  = 1'b1;
            pc_commit = addr_t'({seed[25:18], 2'b00});
            // One target in eight off word alignment
            if (seed[30:28] == 3'd0) begin
                pc_commit[1:0] = 2'd1 + 2'(seed[17:16] % 3);
            end
            exp_pc     = pc_commit;
            fault_seen = 1'b0;
            gap        = 30 + seed[14:10] % 21;
        end else begin
            redirect = 1'b0;
            gap--;
        end
        stall_prev    = stall;
        redirect_prev = redirect;
    endtask

    initial begin
        rstn_i        = 1'b0;
        stall         = 1'b0;
        redirect      = 1'b0;
        pc_commit     = '0;
        seed          = SEED;
        exp_pc        = RESET_PC;
        fault_seen    = 1'b0;
        stall_prev    = 1'b0;
        redirect_prev = 1'b0;
        req_prev      = 1'b0;
        repeat (RESET_CYCLES) begin
            @(negedge clk_i);
            assert (!fetch.valid && !fetch.ex.valid) else report_flow("Packet valid during reset");
            assert (!mem_req.valid) else report_flow("Refill request raised during reset");
        end
        rstn_i = 1'b1;
        repeat (RUN_CYCLES) begin
            @(negedge clk_i);
            check_outputs();
            drive_inputs();
        end
        assert (pkt_cnt > RUN_CYCLES / 10) else report_flow("Too few packets were delivered");
        assert (ex_cnt > 0) else report_flow("No misaligned target reached decode");
        $display("Packets %0d, exceptions %0d, value errors %0d, flow errors %0d",
                 pkt_cnt, ex_cnt, value_errs, flow_errs);
        if (value_errs + flow_errs == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // Hard stop past the expected run length
    always @(posedge clk_i) begin
        cycle_cnt++;
        if (cycle_cnt > TIMEOUT_CYCLES) begin
            $display("Run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

endmodule

// File: verif/fetch_mem_model.sv
// Serves one line refill at a time after 1 to 6 cycles and returns address keyed words
`timescale 1ns/1ps

module fetch_mem_model #(
    parameter fetch_pkg::inst_t KEY  = 32'h0,
    parameter logic [31:0]      SEED = 32'd1
) (
    input  logic                 clk_i,
    input  logic                 rstn_i,
    input  fetch_pkg::mem_req_t  mem_req_i,
    output fetch_pkg::mem_resp_t mem_resp_o
);
    import fetch_pkg::*;

    logic [31:0] seed;
    logic        busy;
    logic [2:0]  wait_cnt;
    addr_t       line_addr;
    mem_resp_t   resp_q = '0;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Reference instruction of a byte address
    function automatic inst_t word_at(input addr_t a);
        return a[31:0] ^ KEY;
    endfunction

    // Lowest address sits in the low word
    function automatic line_t line_at(input addr_t base);
        line_t l;
        for (int w = 0; w < LINE_BITS / INST_BITS; w++) begin
            l[w*INST_BITS +: INST_BITS] = word_at(base + addr_t'(w * 4));
        end
        return l;
    endfunction

    assign mem_resp_o = resp_q;

    // Response changes on the falling edge like the other DUT inputs
    always @(negedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            seed   <= SEED;
            busy   <= 1'b0;
            resp_q <= '0;
        end else if (resp_q.valid) begin
            // Line taken on the last rising edge
            resp_q.valid <= 1'b0;
            busy         <= 1'b0;
        end else if (busy) begin
            if (wait_cnt == 3'd1) begin
                resp_q.valid <= 1'b1;
                resp_q.data  <= line_at(line_addr);
            end
            wait_cnt <= wait_cnt - 3'd1;
        end else if (mem_req_i.valid) begin
            busy      <= 1'b1;
            line_addr <= mem_req_i.line_addr;
            wait_cnt  <= 3'd1 + 3'(seed[20:16] % 6);
            seed      <= lcg_next(seed);
        end
    end

endmodule

// File: design/fetch_top.sv
// Fetch front end with a private cache and one external refill port for a single miss
`timescale 1ns/1ps

module fetch_top (
    input  logic                     clk_i,
    input  logic                     rstn_i,
    // Decode stall level
    input  logic                     stall_i,
    // Commit redirect pulse and target
    input  logic                     redirect_i,
    input  fetch_pkg::addr_t         pc_commit_i,
    // Refill port to memory
    input  fetch_pkg::mem_resp_t     mem_resp_i,
    output fetch_pkg::mem_req_t      mem_req_o,
    // Packet to decode
    output fetch_pkg::if_id_stage_t  fetch_o
);
    import fetch_pkg::*;

    // Fetch to cache lookup
    req_cpu_icache_t  req_cpu_icache;
    // Cache hit data back
    resp_icache_cpu_t resp_icache_cpu;

    // PC and packet register
    if_stage if_stage0 (
        .clk_i             (clk_i),
        .rstn_i            (rstn_i),
        .stall_i           (stall_i),
        .redirect_i        (redirect_i),
        .pc_commit_i       (pc_commit_i),
        .resp_icache_cpu_i (resp_icache_cpu),
        .req_cpu_icache_o  (req_cpu_icache),
        .fetch_o           (fetch_o)
    );

    // Instruction cache
    // Refill goes straight out of the top
    icache icache0 (
        .clk_i             (clk_i),
        .rstn_i            (rstn_i),
        .req_cpu_icache_i  (req_cpu_icache),
        .mem_resp_i        (mem_resp_i),
        .resp_icache_cpu_o (resp_icache_cpu),
        .mem_req_o         (mem_req_o)
    );

endmodule

// File: design/icache.sv
// Blocking direct-mapped cache with one miss at a time and no invalidation apart from reset
`timescale 1ns/1ps

module icache (
    input  logic                        clk_i,
    input  logic                        rstn_i,
    // Lookup from fetch
    input  fetch_pkg::req_cpu_icache_t  req_cpu_icache_i,
    // Whole line back from memory in one beat
    input  fetch_pkg::mem_resp_t        mem_resp_i,
    // Hit data back to fetch
    output fetch_pkg::resp_icache_cpu_t resp_icache_cpu_o,
    // Line request, held as a level
    output fetch_pkg::mem_req_t         mem_req_o
);
    import fetch_pkg::*;

    // Line storage
    logic [ICACHE_LINES-1:0] valid_q;
    tag_t                    tag_q  [ICACHE_LINES];
    line_t                   data_q [ICACHE_LINES];

    // Refill control
    icache_state_t state_q;
    icache_state_t state_d;
    tag_t          miss_tag_q;
    index_t        miss_idx_q;

    // Lookup fields
    tag_t                     req_tag;
    index_t                   req_idx;
    logic [WORD_SEL_BITS-1:0] req_word;
    line_t                    rd_line;
    logic                     lookup_en;
    logic                     tag_match;
    logic                     hit;
    logic                     miss;
    logic                     refill_done;

    // Address split
    // Tag on top, then index, then line offset
    assign req_tag  = req_cpu_icache_i.vaddr[ADDR_BITS-1 -: TAG_BITS];
    assign req_idx  = req_cpu_icache_i.vaddr[LINE_OFFSET_BITS +: INDEX_BITS];
    // Bits 3 to 2 pick the word
    assign req_word = req_cpu_icache_i.vaddr[INST_OFFSET_BITS +: WORD_SEL_BITS];

    // Read port of the line array
    assign rd_line   = data_q[req_idx];
    assign tag_match = valid_q[req_idx] && (tag_q[req_idx] == req_tag);

    // Lookups only served while idle
    // Anything during a refill sees no response
    assign lookup_en = req_cpu_icache_i.valid && (state_q == IDLE);
    assign hit       = lookup_en && tag_match;
    assign miss      = lookup_en && !tag_match;

    // Line arrives in the cycle memory raises valid
    assign refill_done = (state_q == REFILL) && mem_resp_i.valid;

    // Same-cycle response on a hit
    assign resp_icache_cpu_o.valid = hit;
    assign resp_icache_cpu_o.data  = rd_line[req_word*INST_BITS +: INST_BITS];

    // Request level stays up for the whole refill
    // including the cycle the line comes back
    assign mem_req_o.valid     = (state_q == REFILL);
    assign mem_req_o.line_addr = {miss_tag_q, miss_idx_q, {LINE_OFFSET_BITS{1'b0}}};

    // Refill FSM
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                // Miss starts a refill
                if (miss) begin
                    state_d = REFILL;
                end
            end
            REFILL: begin
                // Back to lookups once the line is written
                if (mem_resp_i.valid) begin
                    state_d = IDLE;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Line valid bits
    // All lines empty after reset
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            valid_q <= '0;
        end else if (refill_done) begin
            valid_q[miss_idx_q] <= 1'b1;
        end
    end

    // Miss address captured on the missing lookup
    // Kept even if fetch moves on after a redirect
    always_ff @(posedge clk_i) begin
        if (miss) begin
            miss_tag_q <= req_tag;
            miss_idx_q <= req_idx;
        end
    end

    // Tag and data write on refill
    always_ff @(posedge clk_i) begin
        if (refill_done) begin
            tag_q[miss_idx_q]  <= miss_tag_q;
            data_q[miss_idx_q] <= mem_resp_i.data;
        end
    end

endmodule

// File: design/if_stage.sv
// No branch prediction here and a misaligned PC stops fetch until the next redirect
`timescale 1ns/1ps

module if_stage (
    input  logic                        clk_i,
    input  logic                        rstn_i,
    // Decode back-pressure
    input  logic                        stall_i,
    // One-cycle redirect from commit
    input  logic                        redirect_i,
    input  fetch_pkg::addr_t            pc_commit_i,
    // Lookup result from the cache
    input  fetch_pkg::resp_icache_cpu_t resp_icache_cpu_i,
    output fetch_pkg::req_cpu_icache_t  req_cpu_icache_o,
    // Registered packet to decode
    output fetch_pkg::if_id_stage_t     fetch_o
);
    import fetch_pkg::*;

    next_pc_sel_t     next_pc_sel;
    addr_t            next_pc;
    addr_t            pc_q;
    logic             misaligned;
    logic             fault_q;
    logic             raise_ex;
    logic             load_pkt;
    // Packet control
    logic             valid_q;
    logic             ex_valid_q;
    // Packet payload
    addr_t            pc_inst_q;
    inst_t            inst_q;
    exception_cause_t ex_cause_q;
    addr_t            ex_origin_q;

    // Low PC bits must be zero for a word fetch
    assign misaligned = |pc_q[INST_OFFSET_BITS-1:0];
    // Exception packet goes out once per fault
    assign raise_ex   = misaligned && !fault_q;
    // Packet register moves unless stalled or flushed
    assign load_pkt   = !stall_i && !redirect_i;

    // Redirect wins over stall
    always_comb begin
        if (redirect_i) begin
            next_pc_sel = NEXT_PC_SEL_COMMIT;
        end else if (resp_icache_cpu_i.valid && !stall_i) begin
            next_pc_sel = NEXT_PC_SEL_PC_4;
        end else begin
            next_pc_sel = NEXT_PC_SEL_PC;
        end
    end

    always_comb begin
        case (next_pc_sel)
            NEXT_PC_SEL_PC_4:   next_pc = pc_q + addr_t'(INST_BITS / 8);
            NEXT_PC_SEL_COMMIT: next_pc = pc_commit_i;
            default:            next_pc = pc_q;
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            pc_q <= RESET_PC;
        end else begin
            pc_q <= next_pc;
        end
    end

    // Sticky fault cleared only by a redirect
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            fault_q <= 1'b0;
        end else if (redirect_i) begin
            fault_q <= 1'b0;
        end else if (load_pkt && raise_ex) begin
            fault_q <= 1'b1;
        end
    end

    // No lookup from a misaligned PC
    assign req_cpu_icache_o.valid = !misaligned;
    assign req_cpu_icache_o.vaddr = pc_q;

    // Flush on redirect and hold on stall
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            valid_q    <= 1'b0;
            ex_valid_q <= 1'b0;
        end else if (redirect_i) begin
            valid_q    <= 1'b0;
            ex_valid_q <= 1'b0;
        end else if (!stall_i) begin
            valid_q    <= resp_icache_cpu_i.valid || raise_ex;
            ex_valid_q <= raise_ex;
        end
    end

    always_ff @(posedge clk_i) begin
        if (load_pkt) begin
            pc_inst_q   <= pc_q;
            inst_q      <= raise_ex ? '0 : resp_icache_cpu_i.data;
            ex_cause_q  <= raise_ex ? MISALIGNED_FETCH : NONE;
            ex_origin_q <= raise_ex ? pc_q : '0;
        end
    end

    assign fetch_o.pc_inst         = pc_inst_q;
    assign fetch_o.inst            = inst_q;
    assign fetch_o.valid           = valid_q;
    // Static not-taken prediction
    assign fetch_o.bpred.decision  = PRED_NOT_TAKEN;
    assign fetch_o.bpred.pred_addr = '0;
    assign fetch_o.ex.cause        = ex_cause_q;
    assign fetch_o.ex.origin       = ex_origin_q;
    assign fetch_o.ex.valid        = ex_valid_q;

endmodule

// File: design/fetch_pkg.sv
// Fixed 40-bit byte addresses and 128-bit lines of four words without compressed instructions
package fetch_pkg;

    // Base widths
    localparam int unsigned ADDR_BITS = 40;
    localparam int unsigned INST_BITS = 32;
    localparam int unsigned LINE_BITS = 128;

    // Cache geometry derived from the widths above
    localparam int unsigned ICACHE_LINES     = 16;
    localparam int unsigned LINE_OFFSET_BITS = $clog2(LINE_BITS / 8);
    localparam int unsigned INDEX_BITS       = $clog2(ICACHE_LINES);
    localparam int unsigned TAG_BITS         = ADDR_BITS - INDEX_BITS - LINE_OFFSET_BITS;
    // Byte offset inside one instruction
    localparam int unsigned INST_OFFSET_BITS = $clog2(INST_BITS / 8);
    // Word select inside one line
    localparam int unsigned WORD_SEL_BITS    = LINE_OFFSET_BITS - INST_OFFSET_BITS;

    typedef logic [ADDR_BITS-1:0]  addr_t;
    typedef logic [INST_BITS-1:0]  inst_t;
    typedef logic [LINE_BITS-1:0]  line_t;
    typedef logic [TAG_BITS-1:0]   tag_t;
    typedef logic [INDEX_BITS-1:0] index_t;

    // First fetch address out of reset
    localparam addr_t RESET_PC = 40'h00_0000_0100;

    // Next PC source
    typedef enum logic [1:0] {
        NEXT_PC_SEL_PC     = 2'b00,
        NEXT_PC_SEL_PC_4   = 2'b01,
        NEXT_PC_SEL_COMMIT = 2'b10
    } next_pc_sel_t;

    typedef enum logic {
        PRED_NOT_TAKEN = 1'b0,
        PRED_TAKEN     = 1'b1
    } branch_pred_decision_t;

    // Cause code follows the RISC-V numbering for a misaligned fetch
    typedef enum logic [3:0] {
        MISALIGNED_FETCH = 4'h0,
        NONE             = 4'hF
    } exception_cause_t;

    // Refill controller of the cache
    typedef enum logic {
        IDLE   = 1'b0,
        REFILL = 1'b1
    } icache_state_t;

    typedef struct packed {
        branch_pred_decision_t decision;
        addr_t                 pred_addr;
    } bpred_t;

    typedef struct packed {
        exception_cause_t cause;
        addr_t            origin;
        logic             valid;
    } exception_t;

    // Fetch to cache lookup
    typedef struct packed {
        logic  valid;
        addr_t vaddr;
    } req_cpu_icache_t;

    // Cache to fetch response valid only on a hit
    typedef struct packed {
        logic  valid;
        inst_t data;
    } resp_icache_cpu_t;

    // Packet handed to decode
    typedef struct packed {
        addr_t      pc_inst;
        inst_t      inst;
        logic       valid;
        bpred_t     bpred;
        exception_t ex;
    } if_id_stage_t;

    // Line refill request with a line aligned address
    typedef struct packed {
        logic  valid;
        addr_t line_addr;
    } mem_req_t;

    typedef struct packed {
        logic  valid;
        line_t data;
    } mem_resp_t;

endpackage
